// ==== src/addr_decode_pkg.sv ====
package addr_decode_pkg;

    // instruction window
    localparam int window_bytes = 6;

    typedef logic [7:0] inst_byte_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic [1:0] scale_t;
    typedef logic [1:0] mod_t;

    // one-hot byte count of modrm + sib + displacement
    typedef logic [5:0] addr_len_t;

    localparam addr_len_t len_0 = 6'b000001;
    localparam addr_len_t len_1 = 6'b000010;
    localparam addr_len_t len_2 = 6'b000100;
    localparam addr_len_t len_3 = 6'b001000;
    localparam addr_len_t len_5 = 6'b010000;
    localparam addr_len_t len_6 = 6'b100000;

    // one-hot displacement size
    typedef logic [3:0] disp_size_t;

    localparam disp_size_t disp_none = 4'b0001;
    localparam disp_size_t disp_8 = 4'b0010;
    localparam disp_size_t disp_16 = 4'b0100;
    localparam disp_size_t disp_32 = 4'b1000;

    // modrm mod field
    localparam mod_t mod_indirect = 2'd0;
    localparam mod_t mod_disp8 = 2'd1;
    localparam mod_t mod_disp_full = 2'd2;
    localparam mod_t mod_register = 2'd3;

    // fixed registers of 16-bit addressing
    localparam reg_idx_t reg_bx = 3'd3;
    localparam reg_idx_t reg_bp = 3'd5;
    localparam reg_idx_t reg_si = 3'd6;
    localparam reg_idx_t reg_di = 3'd7;

    // special r/m encodings
    localparam reg_idx_t rm_sib = 3'd4;
    localparam reg_idx_t rm_disp_only = 3'd5;
    localparam reg_idx_t rm16_disp_only = 3'd6;

endpackage

// ==== src/addr_info_if.sv ====
interface addr_info_if
    import addr_decode_pkg::*;
();

    logic       is_sib;
    addr_len_t  length;
    disp_size_t disp_size;
    reg_idx_t   base_reg;
    logic       use_base;
    reg_idx_t   index_reg;
    logic       use_index;
    scale_t     scale;

    modport length_src (
        output is_sib,
        output length,
        output disp_size
    );

    // register side needs is_sib from the length side
    modport reg_src (
        input  is_sib,
        output base_reg,
        output use_base,
        output index_reg,
        output use_index,
        output scale
    );

    modport sink (
        input is_sib,
        input length,
        input disp_size,
        input base_reg,
        input use_base,
        input index_reg,
        input use_index,
        input scale
    );

endinterface

// ==== src/prefix_window_select.sv ====
module prefix_window_select
    import addr_decode_pkg::*;
#(
    parameter int max_prefixes = 4,
    parameter int window_bytes = addr_decode_pkg::window_bytes
) (
    // window numbered from 1, byte k+1 follows k prefixes
    input  inst_byte_t              byte_window [1:window_bytes],
    input  logic [max_prefixes-1:0] prefix_count_onehot,
    input  logic                    two_byte_opcode,
    output inst_byte_t              modrm_byte,
    output inst_byte_t              sib_byte
);

    logic [max_prefixes-1:0] prefix_sel;
    inst_byte_t              modrm_cand [max_prefixes];
    inst_byte_t              sib_cand [max_prefixes];

    // illegal one-hot falls back to no prefixes
    assign prefix_sel = $onehot(prefix_count_onehot) ? prefix_count_onehot
                                                     : max_prefixes'(1);

    // candidate bytes per prefix count
    always_comb begin
        for (int i = 0; i < max_prefixes; i++) begin
            if (two_byte_opcode) begin
                modrm_cand[i] = byte_window[i + 2];
                sib_cand[i] = byte_window[i + 3];
            end else begin
                modrm_cand[i] = byte_window[i + 1];
                sib_cand[i] = byte_window[i + 2];
            end
        end
    end

    // and-or mux over the prefix one-hot
    always_comb begin
        modrm_byte = '0;
        sib_byte = '0;
        for (int i = 0; i < max_prefixes; i++) begin
            modrm_byte = modrm_byte | ({8{prefix_sel[i]}} & modrm_cand[i]);
            sib_byte = sib_byte | ({8{prefix_sel[i]}} & sib_cand[i]);
        end
    end

endmodule

// ==== src/modrm_length_decode.sv ====
module modrm_length_decode
    import addr_decode_pkg::*;
(
    input  inst_byte_t       modrm_byte,
    input  logic             has_modrm,
    input  logic             addr_size_override,
    addr_info_if.length_src  info
);

    mod_t     modrm_mod;
    reg_idx_t rm;
    logic     sib_present;

    assign modrm_mod = modrm_byte[7:6];
    assign rm = modrm_byte[2:0];

    // sib only exists in 32-bit addressing
    assign sib_present = has_modrm && (modrm_mod != mod_register) && (rm == rm_sib)
                         && !addr_size_override;

    assign info.is_sib = sib_present;

    always_comb begin
        info.length = len_0;
        info.disp_size = disp_none;
        if (!has_modrm) begin
            info.length = len_0;
            info.disp_size = disp_none;
        end else if (!addr_size_override) begin
            case (modrm_mod)
                mod_indirect: begin
                    // sib base field is not looked at here
                    if (sib_present) begin
                        info.length = len_2;
                        info.disp_size = disp_none;
                    end else if (rm == rm_disp_only) begin
                        info.length = len_5;
                        info.disp_size = disp_32;
                    end else begin
                        info.length = len_1;
                        info.disp_size = disp_none;
                    end
                end
                mod_disp8: begin
                    info.length = sib_present ? len_3 : len_2;
                    info.disp_size = disp_8;
                end
                mod_disp_full: begin
                    info.length = sib_present ? len_6 : len_5;
                    info.disp_size = disp_32;
                end
                default: begin
                    info.length = len_1;
                    info.disp_size = disp_none;
                end
            endcase
        end else begin
            // 16-bit forms
            case (modrm_mod)
                mod_indirect: begin
                    if (rm == rm16_disp_only) begin
                        info.length = len_3;
                        info.disp_size = disp_16;
                    end else begin
                        info.length = len_1;
                        info.disp_size = disp_none;
                    end
                end
                mod_disp8: begin
                    info.length = len_2;
                    info.disp_size = disp_8;
                end
                mod_disp_full: begin
                    info.length = len_3;
                    info.disp_size = disp_16;
                end
                default: begin
                    info.length = len_1;
                    info.disp_size = disp_none;
                end
            endcase
        end
    end

endmodule

// ==== src/addr_reg_select.sv ====
module addr_reg_select
    import addr_decode_pkg::*;
(
    input  inst_byte_t    modrm_byte,
    input  inst_byte_t    sib_byte,
    input  logic          has_modrm,
    input  logic          addr_size_override,
    addr_info_if.reg_src  info
);

    mod_t     modrm_mod;
    reg_idx_t rm;
    scale_t   sib_scale;
    reg_idx_t sib_index;
    reg_idx_t sib_base;
    logic     mode16_mem;
    logic     base16;
    logic     base32;

    assign modrm_mod = modrm_byte[7:6];
    assign rm = modrm_byte[2:0];
    assign sib_scale = sib_byte[7:6];
    assign sib_index = sib_byte[5:3];
    assign sib_base = sib_byte[2:0];

    // 16-bit memory form
    assign mode16_mem = addr_size_override && has_modrm && (modrm_mod != mod_register);

    always_comb begin
        info.base_reg = rm;
        info.index_reg = sib_index;
        info.scale = '0;
        if (info.is_sib) begin
            info.base_reg = sib_base;
            info.index_reg = sib_index;
            info.scale = sib_scale;
        end else if (addr_size_override && (modrm_mod != mod_register)) begin
            // bp for r/m 2, 3 and 6, bx otherwise
            if (rm == 3'd2 || rm == 3'd3 || rm == rm16_disp_only) begin
                info.base_reg = reg_bp;
            end else begin
                info.base_reg = reg_bx;
            end
            info.index_reg = rm[0] ? reg_di : reg_si;
        end
    end

    assign base32 = !addr_size_override && has_modrm
                    && !((modrm_mod == mod_indirect) && (rm == rm_disp_only));

    assign base16 = (mode16_mem && !rm[2])
                    || (mode16_mem && (modrm_mod == mod_indirect) && (rm == 3'd7))
                    || (mode16_mem && (modrm_mod != mod_indirect) && (rm[2:1] == 2'b11));

    // register form counts as a base even without modrm
    assign info.use_base = (modrm_mod == mod_register) || base32 || base16;

    assign info.use_index = info.is_sib || (mode16_mem && (rm <= 3'd5));

endmodule

// ==== src/decode_output_stage.sv ====
module decode_output_stage
    import addr_decode_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    addr_info_if.sink    info,
    output logic         out_valid,
    output logic         is_sib,
    output addr_len_t    length_of_mod_sib_disp,
    output disp_size_t   disp_size,
    output reg_idx_t     base_reg,
    output logic         use_base,
    output reg_idx_t     index_reg,
    output logic         use_index,
    output scale_t       index_scale
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            is_sib <= 1'b0;
            length_of_mod_sib_disp <= '0;
            disp_size <= '0;
            base_reg <= '0;
            use_base <= 1'b0;
            index_reg <= '0;
            use_index <= 1'b0;
            index_scale <= '0;
        end else begin
            out_valid <= in_valid;
            // hold last result when idle
            if (in_valid) begin
                is_sib <= info.is_sib;
                length_of_mod_sib_disp <= info.length;
                disp_size <= info.disp_size;
                base_reg <= info.base_reg;
                use_base <= info.use_base;
                index_reg <= info.index_reg;
                use_index <= info.use_index;
                index_scale <= info.scale;
            end
        end
    end

endmodule

// ==== src/addressing_decode.sv ====
module addressing_decode
    import addr_decode_pkg::*;
#(
    parameter int max_prefixes = 4,
    localparam int window_size = max_prefixes + 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  inst_byte_t              byte_window [1:window_size],
    input  logic                    has_modrm,
    input  logic [max_prefixes-1:0] prefix_count_onehot,
    input  logic                    two_byte_opcode,
    input  logic                    addr_size_override,
    output logic                    out_valid,
    output logic                    is_sib,
    output addr_len_t               length_of_mod_sib_disp,
    output disp_size_t              disp_size,
    output reg_idx_t                base_reg,
    output logic                    use_base,
    output reg_idx_t                index_reg,
    output logic                    use_index,
    output scale_t                  index_scale
);

    inst_byte_t modrm_byte;
    inst_byte_t sib_byte;

    addr_info_if info ();

    prefix_window_select #(
        .max_prefixes (max_prefixes),
        .window_bytes (window_size)
    ) i_prefix_window_select (
        .byte_window         (byte_window),
        .prefix_count_onehot (prefix_count_onehot),
        .two_byte_opcode     (two_byte_opcode),
        .modrm_byte          (modrm_byte),
        .sib_byte            (sib_byte)
    );

    modrm_length_decode i_modrm_length_decode (
        .modrm_byte         (modrm_byte),
        .has_modrm          (has_modrm),
        .addr_size_override (addr_size_override),
        .info               (info.length_src)
    );

    addr_reg_select i_addr_reg_select (
        .modrm_byte         (modrm_byte),
        .sib_byte           (sib_byte),
        .has_modrm          (has_modrm),
        .addr_size_override (addr_size_override),
        .info               (info.reg_src)
    );

    decode_output_stage i_decode_output_stage (
        .clk                    (clk),
        .reset                  (reset),
        .in_valid               (in_valid),
        .info                   (info.sink),
        .out_valid              (out_valid),
        .is_sib                 (is_sib),
        .length_of_mod_sib_disp (length_of_mod_sib_disp),
        .disp_size              (disp_size),
        .base_reg               (base_reg),
        .use_base               (use_base),
        .index_reg              (index_reg),
        .use_index              (use_index),
        .index_scale            (index_scale)
    );

endmodule

// ==== verification/addressing_decode_vectors.svh ====
task automatic load_vectors();
    // name, in_valid, window bytes 1..6, has_modrm, prefix one-hot, two-byte opcode, 16-bit
    // then is_sib, length, disp, base, use_base, index, use_index, scale
    add_vector("sel_p0_1b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd1, 1'b1, 3'd2, 1'b0, 2'd0);
    add_vector("sel_p0_2b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0001, 1'b1, 1'b0,
               1'b0, len_1, disp_none, 3'd2, 1'b1, 3'd3, 1'b0, 2'd0);
    add_vector("sel_p1_1b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0010, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd2, 1'b1, 3'd3, 1'b0, 2'd0);
    add_vector("sel_p1_2b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0010, 1'b1, 1'b0,
               1'b0, len_1, disp_none, 3'd3, 1'b1, 3'd4, 1'b0, 2'd0);
    add_vector("sel_p2_1b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0100, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd3, 1'b1, 3'd4, 1'b0, 2'd0);
    add_vector("sel_p2_2b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b0100, 1'b1, 1'b0,
               1'b0, len_1, disp_none, 3'd4, 1'b1, 3'd5, 1'b0, 2'd0);
    add_vector("sel_p3_1b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b1000, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd4, 1'b1, 3'd5, 1'b0, 2'd0);
    add_vector("sel_p3_2b", 1'b1, 48'hC9D2DBE4EDF6, 1'b1, 4'b1000, 1'b1, 1'b0,
               1'b0, len_1, disp_none, 3'd5, 1'b1, 3'd6, 1'b0, 2'd0);
    // idle rows expect the previous result held
    add_vector("idle_hold", 1'b0, 48'h048D00000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd5, 1'b1, 3'd6, 1'b0, 2'd0);
    add_vector("m0_rm0", 1'b1, 48'h001800000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd0, 1'b1, 3'd3, 1'b0, 2'd0);
    add_vector("m0_sib", 1'b1, 48'h048D00000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b1, len_2, disp_none, 3'd5, 1'b1, 3'd1, 1'b1, 2'd2);
    add_vector("m0_rm5", 1'b1, 48'h050000000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_5, disp_32, 3'd5, 1'b0, 3'd0, 1'b0, 2'd0);
    add_vector("m1_rm3", 1'b1, 48'h430000000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_2, disp_8, 3'd3, 1'b1, 3'd0, 1'b0, 2'd0);
    add_vector("m1_sib", 1'b1, 48'h441A00000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b1, len_3, disp_8, 3'd2, 1'b1, 3'd3, 1'b1, 2'd0);
    add_vector("m1_sib_s1", 1'b1, 48'h447000000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b1, len_3, disp_8, 3'd0, 1'b1, 3'd6, 1'b1, 2'd1);
    add_vector("m2_rm5", 1'b1, 48'h850000000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_5, disp_32, 3'd5, 1'b1, 3'd0, 1'b0, 2'd0);
    add_vector("m2_sib", 1'b1, 48'h84E700000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b1, len_6, disp_32, 3'd7, 1'b1, 3'd4, 1'b1, 2'd3);
    add_vector("idle_hold2", 1'b0, 48'h000000000000, 1'b0, 4'b0001, 1'b0, 1'b0,
               1'b1, len_6, disp_32, 3'd7, 1'b1, 3'd4, 1'b1, 2'd3);
    add_vector("m3_rm4", 1'b1, 48'hC40000000000, 1'b1, 4'b0001, 1'b0, 1'b0,
               1'b0, len_1, disp_none, 3'd4, 1'b1, 3'd0, 1'b0, 2'd0);
    add_vector("no_modrm", 1'b1, 48'h441A00000000, 1'b0, 4'b0001, 1'b0, 1'b0,
               1'b0, len_0, disp_none, 3'd4, 1'b0, 3'd3, 1'b0, 2'd0);
    add_vector("w16_rm0", 1'b1, 48'h000000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd3, 1'b1, 3'd6, 1'b1, 2'd0);
    add_vector("w16_rm1", 1'b1, 48'h010000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd3, 1'b1, 3'd7, 1'b1, 2'd0);
    add_vector("w16_rm2", 1'b1, 48'h020000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd5, 1'b1, 3'd6, 1'b1, 2'd0);
    add_vector("w16_rm3", 1'b1, 48'h030000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd5, 1'b1, 3'd7, 1'b1, 2'd0);
    // sib byte present in the window but 16-bit has no sib
    add_vector("w16_rm4", 1'b1, 48'h04E700000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd3, 1'b0, 3'd6, 1'b1, 2'd0);
    add_vector("w16_rm5", 1'b1, 48'h050000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd3, 1'b0, 3'd7, 1'b1, 2'd0);
    add_vector("w16_rm6", 1'b1, 48'h060000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_3, disp_16, 3'd5, 1'b0, 3'd6, 1'b0, 2'd0);
    add_vector("w16_rm7", 1'b1, 48'h070000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd3, 1'b1, 3'd7, 1'b0, 2'd0);
    add_vector("w16_m1_rm2", 1'b1, 48'h420000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_2, disp_8, 3'd5, 1'b1, 3'd6, 1'b1, 2'd0);
    add_vector("w16_m1_rm6", 1'b1, 48'h460000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_2, disp_8, 3'd5, 1'b1, 3'd6, 1'b0, 2'd0);
    add_vector("w16_m2_rm7", 1'b1, 48'h870000000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_3, disp_16, 3'd3, 1'b1, 3'd7, 1'b0, 2'd0);
    add_vector("w16_m3_rm5", 1'b1, 48'hC51800000000, 1'b1, 4'b0001, 1'b0, 1'b1,
               1'b0, len_1, disp_none, 3'd5, 1'b1, 3'd3, 1'b0, 2'd0);
    // register form flags a base even with has_modrm low
    add_vector("q_m3_nomodrm", 1'b1, 48'hC21800000000, 1'b0, 4'b0001, 1'b0, 1'b0,
               1'b0, len_0, disp_none, 3'd2, 1'b1, 3'd3, 1'b0, 2'd0);
    add_vector("q_m3_nomodrm16", 1'b1, 48'hC61800000000, 1'b0, 4'b0001, 1'b0, 1'b1,
               1'b0, len_0, disp_none, 3'd6, 1'b1, 3'd3, 1'b0, 2'd0);
endtask

// ==== verification/addressing_decode_tb.sv ====
module addressing_decode_tb
    import addr_decode_pkg::*;
();

    localparam int clk_period = 10;
    localparam int reset_cycles = 8;
    localparam int drive_delay = 1;
    localparam int prefix_bits = window_bytes - 2;

    // one table row with stimulus and expected outputs
    typedef struct packed {
        logic                      valid;
        logic [8*window_bytes-1:0] window;
        logic                      has_modrm;
        logic [prefix_bits-1:0]    prefix;
        logic                      two_byte;
        logic                      mode16;
        logic                      is_sib;
        addr_len_t                 len;
        disp_size_t                disp;
        reg_idx_t                  base;
        logic                      use_base;
        reg_idx_t                  index;
        logic                      use_index;
        scale_t                    scale;
    } vector_t;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    inst_byte_t             byte_window [1:window_bytes];
    logic                   has_modrm;
    logic [prefix_bits-1:0] prefix_count_onehot;
    logic                   two_byte_opcode;
    logic                   addr_size_override;
    logic                   out_valid;
    logic                   is_sib;
    addr_len_t              length_of_mod_sib_disp;
    disp_size_t             disp_size;
    reg_idx_t               base_reg;
    logic                   use_base;
    reg_idx_t               index_reg;
    logic                   use_index;
    scale_t                 index_scale;

    vector_t vectors[$];
    string   names[$];
    int      error_count;
    int      failed_tests;
    logic    vectors_loaded = 1'b0;

    addressing_decode i_addressing_decode (
        .clk                    (clk),
        .reset                  (reset),
        .in_valid               (in_valid),
        .byte_window            (byte_window),
        .has_modrm              (has_modrm),
        .prefix_count_onehot    (prefix_count_onehot),
        .two_byte_opcode        (two_byte_opcode),
        .addr_size_override     (addr_size_override),
        .out_valid              (out_valid),
        .is_sib                 (is_sib),
        .length_of_mod_sib_disp (length_of_mod_sib_disp),
        .disp_size              (disp_size),
        .base_reg               (base_reg),
        .use_base               (use_base),
        .index_reg              (index_reg),
        .use_index              (use_index),
        .index_scale            (index_scale)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic add_vector(input string name, input logic valid,
                              input logic [8*window_bytes-1:0] window, input logic has,
                              input logic [prefix_bits-1:0] prefix, input logic two_byte,
                              input logic mode16, input logic sib, input addr_len_t len,
                              input disp_size_t disp, input reg_idx_t base, input logic ub,
                              input reg_idx_t index, input logic ui, input scale_t scale);
        vector_t v;
        v = '{valid, window, has, prefix, two_byte, mode16, sib, len, disp, base, ub, index,
              ui, scale};
        vectors.push_back(v);
        names.push_back(name);
    endtask

    `include "addressing_decode_vectors.svh"

    task automatic check_len(input string test, input addr_len_t expected,
                             input addr_len_t actual);
        if (actual !== expected) begin
            $display("mismatch %s length: expected %b, actual %b", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_disp(input string test, input disp_size_t expected,
                              input disp_size_t actual);
        if (actual !== expected) begin
            $display("mismatch %s disp_size: expected %b, actual %b", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_reg(input string test, input string field, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %0d, actual %0d", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_scale(input string test, input scale_t expected, input scale_t actual);
        if (actual !== expected) begin
            $display("mismatch %s scale: expected %0d, actual %0d", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string test, input string field, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %b, actual %b", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic drive_vector(input vector_t v);
        in_valid = v.valid;
        // byte 1 sits in the top byte of the row
        for (int i = 1; i <= window_bytes; i++) begin
            byte_window[i] = v.window[(window_bytes - i) * 8 +: 8];
        end
        has_modrm = v.has_modrm;
        prefix_count_onehot = v.prefix;
        two_byte_opcode = v.two_byte;
        addr_size_override = v.mode16;
    endtask

    task automatic check_outputs(input string test, input vector_t v);
        check_flag(test, "out_valid", v.valid, out_valid);
        check_flag(test, "is_sib", v.is_sib, is_sib);
        check_len(test, v.len, length_of_mod_sib_disp);
        check_disp(test, v.disp, disp_size);
        check_reg(test, "base_reg", v.base, base_reg);
        check_flag(test, "use_base", v.use_base, use_base);
        check_reg(test, "index_reg", v.index, index_reg);
        check_flag(test, "use_index", v.use_index, use_index);
        check_scale(test, v.scale, index_scale);
    endtask

    task automatic report_test(input string test, input int errors_before);
        if (error_count == errors_before) begin
            $display("ok   %s", test);
        end else begin
            $display("fail %s", test);
            failed_tests++;
        end
    endtask

    initial begin
        vector_t reset_expect;
        int      errors_before;
        reset_expect = '0;
        error_count = 0;
        failed_tests = 0;
        reset = 1'b1;
        // valid sib form offered while reset is held
        in_valid = 1'b1;
        has_modrm = 1'b1;
        prefix_count_onehot = prefix_bits'(1);
        two_byte_opcode = 1'b0;
        addr_size_override = 1'b0;
        for (int i = 1; i <= window_bytes; i++) begin
            byte_window[i] = 8'hE7;
        end
        byte_window[1] = 8'h84;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        errors_before = error_count;
        check_outputs("reset", reset_expect);
        report_test("reset", errors_before);
        drive_vector(vectors[0]);
        // each row is checked one cycle after it was driven
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            #drive_delay;
            errors_before = error_count;
            check_outputs(names[i], vectors[i]);
            report_test(names[i], errors_before);
            if (i + 1 < vectors.size()) begin
                drive_vector(vectors[i + 1]);
            end else begin
                in_valid = 1'b0;
            end
        end
        $display("tests run %0d, tests failed %0d, mismatches %0d", vectors.size() + 1,
                 failed_tests, error_count);
        if (failed_tests == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (vectors_loaded);
        limit = (vectors.size() + reset_cycles + 10) * clk_period * 4;
        #(limit);
        $display("watchdog expired before the vector run completed");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== addressing_decode.f ====
+incdir+verification
src/addr_decode_pkg.sv
src/addr_info_if.sv
src/prefix_window_select.sv
src/modrm_length_decode.sv
src/addr_reg_select.sv
src/decode_output_stage.sv
src/addressing_decode.sv
verification/addressing_decode_tb.sv

// ==== Makefile ====
# Verilator build and run for the addressing decoder

VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -j 0
TOP             ?= addressing_decode_tb
FILELIST        ?= addressing_decode.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log

SOURCES := $(wildcard src/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

FAIL_TEXT := FAIL: see errors above
PASS_TEXT := PASS: all tests

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
